// ==== logic/fetchPkg.sv ====
package fetchPkg;

    // fetch address after reset or flush
    localparam logic [31:0] RESET_PC = 32'h0;
    // two 32-bit words per group
    localparam logic [31:0] GROUP_BYTES = 32'd8;
    localparam int GROUP_OFFSET_BITS = 3;

    // next-line table geometry
    localparam int BTB_ENTRIES = 16;
    localparam int BTB_INDEX_BITS = 4;
    localparam int BTB_TAG_BITS = 32 - BTB_INDEX_BITS - GROUP_OFFSET_BITS;

    // opcodes and function codes of control transfers
    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_REGIMM = 6'b000001;
    localparam logic [5:0] OP_J = 6'b000010;
    localparam logic [5:0] OP_JAL = 6'b000011;
    localparam logic [5:0] OP_BEQ = 6'b000100;
    localparam logic [5:0] OP_BNE = 6'b000101;
    localparam logic [5:0] OP_BLEZ = 6'b000110;
    localparam logic [5:0] OP_BGTZ = 6'b000111;
    localparam logic [5:0] FN_JR = 6'b001000;
    localparam logic [5:0] FN_JALR = 6'b001001;

    typedef struct packed {
        logic valid;
        logic taken;
        logic [31:0] target;
    } nlpInfo_t;

    typedef struct packed {
        logic valid;
        logic [31:0] pc;
    } redirect_t;

    typedef struct packed {
        logic valid;
        logic slot;
        logic taken;
        logic [31:0] pc;
        logic [31:0] target;
    } btbUpdate_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst0;
        logic [31:0] inst1;
        nlpInfo_t nlp0;
        nlpInfo_t nlp1;
        logic onlyDs;
    } fetchGroup_t;

    // true for branches and jumps
    function automatic logic isBranchOp(input logic [31:0] inst);
        logic [5:0] opcode;
        logic [5:0] funct;
        logic [4:0] rt;
        logic result;
        opcode = inst[31:26];
        funct = inst[5:0];
        rt = inst[20:16];
        case (opcode)
            OP_SPECIAL: result = (funct == FN_JR) || (funct == FN_JALR);
            // bltz, bgez, bltzal, bgezal
            OP_REGIMM: result = (rt[3:1] == 3'b000);
            OP_J, OP_JAL, OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ: result = 1'b1;
            default: result = 1'b0;
        endcase
        return result;
    endfunction

endpackage

// ==== logic/fetchPcSelect.sv ====
module fetchPcSelect (
    input logic clk,
    input logic reset,
    input logic flush,
    input fetchPkg::redirect_t backendRedirect,
    input fetchPkg::redirect_t ifRedirect,
    input fetchPkg::nlpInfo_t nlp0,
    input fetchPkg::nlpInfo_t nlp1,
    input logic pause,
    output logic [31:0] pc,
    output logic onlyDs
);

    // pending delay-slot redirect and where it goes
    logic dsPending;
    logic [31:0] dsTarget;

    logic [31:0] seqPc;
    logic take0;
    logic take1;
    logic armDs;

    // sequential next group
    assign seqPc = pc + fetchPkg::GROUP_BYTES;

    assign take0 = nlp0.valid && nlp0.taken;
    assign take1 = nlp1.valid && nlp1.taken;

    // slot 1 taken, so fetch its delay slot first
    assign armDs = !pause && !dsPending && !take0 && take1;

    // next group only carries its delay slot
    assign onlyDs = dsPending;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            pc <= fetchPkg::RESET_PC;
            dsPending <= 1'b0;
        end else if (backendRedirect.valid) begin
            pc <= backendRedirect.pc;
            dsPending <= 1'b0;
        end else if (ifRedirect.valid) begin
            // pre-decode undoes a bogus prediction
            pc <= ifRedirect.pc;
            dsPending <= 1'b0;
        end else if (!pause) begin
            // pc was just launched, so its predictions steer the next one
            if (dsPending) begin
                pc <= dsTarget;
                dsPending <= 1'b0;
            end else if (take0) begin
                // delay slot sits in slot 1 of the same group
                pc <= nlp0.target;
            end else if (take1) begin
                pc <= seqPc;
                dsPending <= 1'b1;
            end else begin
                pc <= seqPc;
            end
        end
        // paused, hold pc and pending state
    end

    // remembered target of a slot 1 branch
    always_ff @(posedge clk) begin
        if (armDs) begin
            dsTarget <= nlp1.target;
        end
    end

    // redirect sources must hand over word-aligned pcs
    assert property (@(posedge clk) disable iff (reset)
        backendRedirect.valid |-> backendRedirect.pc[1:0] == 2'b00);
    assert property (@(posedge clk) disable iff (reset)
        ifRedirect.valid |-> ifRedirect.pc[1:0] == 2'b00);

endmodule

// ==== logic/nextLinePredictor.sv ====
module nextLinePredictor (
    input logic clk,
    input logic reset,
    input logic [31:0] pc,
    input fetchPkg::btbUpdate_t btbUpdate,
    output fetchPkg::nlpInfo_t nlp0,
    output fetchPkg::nlpInfo_t nlp1
);

    localparam int IDX_LO = fetchPkg::GROUP_OFFSET_BITS;

    // per-entry state
    logic [fetchPkg::BTB_ENTRIES-1:0] entryValid;
    logic [fetchPkg::BTB_TAG_BITS-1:0] entryTag [fetchPkg::BTB_ENTRIES];
    logic [1:0] entryTaken [fetchPkg::BTB_ENTRIES];
    logic [31:0] entryTarget [fetchPkg::BTB_ENTRIES];

    // lookup side
    logic [fetchPkg::BTB_INDEX_BITS-1:0] rdIdx;
    logic [fetchPkg::BTB_TAG_BITS-1:0] rdTag;
    logic hit;

    // training side
    logic [fetchPkg::BTB_INDEX_BITS-1:0] updIdx;
    logic [fetchPkg::BTB_TAG_BITS-1:0] updTag;
    logic sameLine;
    logic [1:0] updTaken;

    // index from the bits just above the group offset
    assign rdIdx = pc[IDX_LO +: fetchPkg::BTB_INDEX_BITS];
    assign rdTag = pc[31 -: fetchPkg::BTB_TAG_BITS];
    assign hit = entryValid[rdIdx] && (entryTag[rdIdx] == rdTag);

    always_comb begin
        nlp0.valid = hit;
        nlp0.taken = hit && entryTaken[rdIdx][0];
        nlp0.target = entryTarget[rdIdx];
        // one target per line, shared by both slots
        nlp1.valid = hit;
        nlp1.taken = hit && entryTaken[rdIdx][1];
        nlp1.target = entryTarget[rdIdx];
    end

    assign updIdx = btbUpdate.pc[IDX_LO +: fetchPkg::BTB_INDEX_BITS];
    assign updTag = btbUpdate.pc[31 -: fetchPkg::BTB_TAG_BITS];

    // keep the other slot's bit only if the line is already ours
    assign sameLine = entryValid[updIdx] && (entryTag[updIdx] == updTag);

    always_comb begin
        updTaken = sameLine ? entryTaken[updIdx] : 2'b00;
        updTaken[btbUpdate.slot] = btbUpdate.taken;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            entryValid <= '0;
        end else if (btbUpdate.valid) begin
            entryValid[updIdx] <= 1'b1;
        end
    end

    // table payload
    always_ff @(posedge clk) begin
        if (btbUpdate.valid) begin
            entryTag[updIdx] <= updTag;
            entryTaken[updIdx] <= updTaken;
            entryTarget[updIdx] <= btbUpdate.target;
        end
    end

    // a training target has to be a word address
    assert property (@(posedge clk) disable iff (reset)
        btbUpdate.valid && btbUpdate.taken |-> btbUpdate.target[1:0] == 2'b00);

endmodule

// ==== logic/instMemPort.sv ====
module instMemPort (
    input logic clk,
    input logic reset,
    input logic flush,
    input logic hold,
    input logic [31:0] pc,
    input logic onlyDs,
    input fetchPkg::nlpInfo_t nlp0,
    input fetchPkg::nlpInfo_t nlp1,
    input fetchPkg::redirect_t ifRedirect,
    input fetchPkg::redirect_t backendRedirect,
    output logic memReq,
    output logic [31:0] memAddr,
    input logic [63:0] memData,
    input logic memAck,
    output logic pause,
    output fetchPkg::fetchGroup_t group,
    output logic groupValid
);

    typedef enum logic [1:0] {IDLE, REQUEST, RELEASE, COMPLETE} portState_t;

    portState_t state;
    // transaction belongs to a squashed path
    logic drop;
    logic kill;
    logic start;
    fetchPkg::fetchGroup_t pending;

    assign kill = flush || backendRedirect.valid || ifRedirect.valid;

    // no launch under back-pressure or while the pc is being redirected
    assign start = (state == IDLE) && !hold && !kill;

    // pc may only move in a cycle that launches it
    assign pause = (state != IDLE) || hold;

    assign memReq = (state == REQUEST);
    assign memAddr = pending.pc;

    assign group = pending;
    assign groupValid = (state == COMPLETE) && !drop && !kill;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
            drop <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state <= REQUEST;
                    end
                end
                // wait for ack high with data
                REQUEST: begin
                    if (memAck) begin
                        state <= RELEASE;
                    end
                end
                // req is down and ack still has to fall
                RELEASE: begin
                    if (!memAck) begin
                        state <= COMPLETE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
            if (start) begin
                drop <= 1'b0;
            end else if (kill && state != IDLE) begin
                drop <= 1'b1;
            end
        end
    end

    // address and predictions captured at launch and words at ack
    always_ff @(posedge clk) begin
        if (start) begin
            pending.pc <= pc;
            pending.onlyDs <= onlyDs;
            pending.nlp0 <= nlp0;
            pending.nlp1 <= nlp1;
        end
        if (state == REQUEST && memAck) begin
            // lower word is the lower address
            pending.inst0 <= memData[31:0];
            pending.inst1 <= memData[63:32];
        end
    end

    // memory side must have dropped ack before a new req
    assert property (@(posedge clk) disable iff (reset) $rose(memReq) |-> !memAck);

endmodule

// ==== logic/predecodeCheck.sv ====
module predecodeCheck (
    input logic clk,
    input logic reset,
    input logic flush,
    input logic hold,
    input fetchPkg::redirect_t backendRedirect,
    input fetchPkg::fetchGroup_t group,
    input logic groupValid,
    output fetchPkg::fetchGroup_t fetchOut,
    output logic fetchValid,
    output fetchPkg::redirect_t ifRedirect
);

    logic full;
    fetchPkg::fetchGroup_t held;

    logic kill;
    logic emit;
    logic take0;
    logic take1;
    logic bogus0;
    logic bogus1;

    assign kill = flush || backendRedirect.valid;
    assign emit = full && !hold && !kill;

    // the predictions that fetch actually followed
    // a delay-slot group followed none of its own
    assign take0 = held.nlp0.valid && held.nlp0.taken && !held.onlyDs;
    assign take1 = held.nlp1.valid && held.nlp1.taken && !held.onlyDs && !take0;

    // taken on something that is no branch
    assign bogus0 = take0 && !fetchPkg::isBranchOp(held.inst0);
    assign bogus1 = take1 && !fetchPkg::isBranchOp(held.inst1);

    always_comb begin
        fetchOut = held;
        fetchOut.nlp0.taken = take0 && !bogus0;
        fetchOut.nlp1.taken = take1 && !bogus1;
    end

    assign fetchValid = emit;

    // both slots were fetched, resume right after the group
    assign ifRedirect.valid = emit && (bogus0 || bogus1);
    assign ifRedirect.pc = held.pc + fetchPkg::GROUP_BYTES;

    always_ff @(posedge clk) begin
        if (reset) begin
            full <= 1'b0;
        end else if (groupValid) begin
            full <= 1'b1;
        end else if (kill || emit) begin
            // squashed or handed over
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (groupValid) begin
            held <= group;
        end
    end

    // one registered group at a time
    assert property (@(posedge clk) disable iff (reset)
        groupValid |-> !full || emit || kill);

endmodule

// ==== logic/fetchFrontend.sv ====
module fetchFrontend (
    input logic clk,
    input logic reset,
    input logic flush,
    input logic hold,
    input fetchPkg::redirect_t backendRedirect,
    input fetchPkg::btbUpdate_t btbUpdate,
    output logic memReq,
    output logic [31:0] memAddr,
    input logic [63:0] memData,
    input logic memAck,
    output fetchPkg::fetchGroup_t fetchOut,
    output logic fetchValid
);

    logic [31:0] pc;
    logic onlyDs;
    logic pause;
    fetchPkg::nlpInfo_t nlp0;
    fetchPkg::nlpInfo_t nlp1;
    fetchPkg::redirect_t ifRedirect;
    fetchPkg::fetchGroup_t group;
    logic groupValid;

    // fetch address and redirect priority
    fetchPcSelect pcSelect_i (
        .clk(clk),
        .reset(reset),
        .flush(flush),
        .backendRedirect(backendRedirect),
        .ifRedirect(ifRedirect),
        .nlp0(nlp0),
        .nlp1(nlp1),
        .pause(pause),
        .pc(pc),
        .onlyDs(onlyDs)
    );

    // same-cycle prediction for pc
    nextLinePredictor predictor_i (
        .clk(clk),
        .reset(reset),
        .pc(pc),
        .btbUpdate(btbUpdate),
        .nlp0(nlp0),
        .nlp1(nlp1)
    );

    instMemPort memPort_i (
        .clk(clk),
        .reset(reset),
        .flush(flush),
        .hold(hold),
        .pc(pc),
        .onlyDs(onlyDs),
        .nlp0(nlp0),
        .nlp1(nlp1),
        .ifRedirect(ifRedirect),
        .backendRedirect(backendRedirect),
        .memReq(memReq),
        .memAddr(memAddr),
        .memData(memData),
        .memAck(memAck),
        .pause(pause),
        .group(group),
        .groupValid(groupValid)
    );

    // checks predictions against the fetched words
    predecodeCheck predecode_i (
        .clk(clk),
        .reset(reset),
        .flush(flush),
        .hold(hold),
        .backendRedirect(backendRedirect),
        .group(group),
        .groupValid(groupValid),
        .fetchOut(fetchOut),
        .fetchValid(fetchValid),
        .ifRedirect(ifRedirect)
    );

endmodule

// ==== dv/instMemModel.sv ====
module instMemModel (
    input logic clk,
    input logic reset,
    input logic [2:0] ackDelay,
    input logic memReq,
    input logic [31:0] memAddr,
    output logic [63:0] memData,
    output logic memAck,
    output logic [9:0] imageIdx,
    input logic [63:0] imageWord
);

    logic counting;
    logic [2:0] waitCount;

    // image decodes address bits 12..3, one 64-bit group per entry
    assign imageIdx = memAddr[12:3];

    always_ff @(posedge clk) begin
        if (reset) begin
            memAck <= 1'b0;
            memData <= '0;
            counting <= 1'b0;
            waitCount <= '0;
        end else if (!memAck) begin
            if (memReq && !counting) begin
                // new request, latch its random latency
                counting <= 1'b1;
                waitCount <= ackDelay;
            end else if (counting) begin
                if (waitCount == 3'd0) begin
                    memAck <= 1'b1;
                    memData <= imageWord;
                    counting <= 1'b0;
                end else begin
                    waitCount <= waitCount - 3'd1;
                end
            end
        end else if (!memReq) begin
            // req dropped, finish the four phases
            memAck <= 1'b0;
        end
    end

endmodule

// ==== dv/fetchTb.sv ====
module fetchTb;

    localparam int CLK_PERIOD = 100;
    localparam int NUM_GROUPS = 400;
    localparam int IMAGE_GROUPS = 1024;

    logic clk;
    logic reset;
    logic flush;
    logic hold;
    fetchPkg::redirect_t backendRedirect;
    fetchPkg::btbUpdate_t btbUpdate;
    logic memReq;
    logic [31:0] memAddr;
    logic [63:0] memData;
    logic memAck;
    fetchPkg::fetchGroup_t fetchOut;
    logic fetchValid;
    logic [2:0] ackDelay;
    logic [9:0] imageIdx;
    logic [63:0] imageWord;

    // program image, word at the lower address in the low half
    logic [63:0] image [IMAGE_GROUPS];
    logic [31:0] rngState;
    int holdLeft;

    // reference model state
    logic [31:0] modelPc;
    logic dsPending;
    logic [31:0] dsTarget;
    logic tblValid [fetchPkg::BTB_ENTRIES];
    logic [24:0] tblTag [fetchPkg::BTB_ENTRIES];
    logic [1:0] tblTaken [fetchPkg::BTB_ENTRIES];
    logic [31:0] tblTarget [fetchPkg::BTB_ENTRIES];
    fetchPkg::fetchGroup_t expected[$];
    logic prevMemReq;

    // scenario counters
    int checkedCount;
    int takenSeen;
    int dsSeen;
    int bogusSeen;
    int redirectSeen;

    assign imageWord = image[imageIdx];

    fetchFrontend fetchFrontend_i (
        .clk(clk),
        .reset(reset),
        .flush(flush),
        .hold(hold),
        .backendRedirect(backendRedirect),
        .btbUpdate(btbUpdate),
        .memReq(memReq),
        .memAddr(memAddr),
        .memData(memData),
        .memAck(memAck),
        .fetchOut(fetchOut),
        .fetchValid(fetchValid)
    );

    instMemModel instMemModel_i (
        .clk(clk),
        .reset(reset),
        .ackDelay(ackDelay),
        .memReq(memReq),
        .memAddr(memAddr),
        .memData(memData),
        .memAck(memAck),
        .imageIdx(imageIdx),
        .imageWord(imageWord)
    );

    function automatic logic [31:0] nextRandom();
        rngState = rngState * 32'd1664525 + 32'd1013904223;
        return rngState;
    endfunction

    // about half the words get a low opcode, so many are branches
    function automatic logic [31:0] randomWord();
        logic [31:0] word;
        word = nextRandom();
        if (word[15]) begin
            word[31:26] = {3'b000, word[14:12]};
        end
        return word;
    endfunction

    // MIPS control transfers, decoded from the opcode table
    function automatic logic isControlTransfer(input logic [31:0] word);
        logic [5:0] op;
        logic [4:0] rt;
        op = word[31:26];
        rt = word[20:16];
        if (op == 6'd0) begin
            // jr and jalr
            return (word[5:0] == 6'd8) || (word[5:0] == 6'd9);
        end
        if (op == 6'd1) begin
            // bltz bgez bltzal bgezal
            return (rt == 5'd0) || (rt == 5'd1) || (rt == 5'd16) || (rt == 5'd17);
        end
        return (op >= 6'd2) && (op <= 6'd7);
    endfunction

    task automatic stopOnError();
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic reportMismatch(input string what, input logic [31:0] got,
                                  input logic [31:0] want);
        $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, want);
        stopOnError();
    endtask

    // random hold periods, training, redirects and ack latency
    task automatic driveStimulus();
        logic [31:0] r;
        logic holdNow;
        fetchPkg::btbUpdate_t upd;
        fetchPkg::redirect_t redir;
        r = nextRandom();
        if (holdLeft > 0) begin
            holdLeft = holdLeft - 1;
        end else if (r[31:28] == 4'd0) begin
            holdLeft = r[27:25] + 1;
        end
        holdNow = (holdLeft > 0);
        hold <= holdNow;
        upd = '0;
        r = nextRandom();
        // train only while fetch is held, near the lines about to be fetched
        if (holdNow && r[31:29] < 3'd3) begin
            upd.valid = 1'b1;
            upd.slot = r[28];
            upd.taken = (r[27:26] != 2'b00);
            upd.pc = modelPc + {27'd0, r[25:24], 3'b000};
            upd.target = {23'd0, r[23:18], 3'b000};
        end
        btbUpdate <= upd;
        redir = '0;
        r = nextRandom();
        if (r[31:26] == 6'd0) begin
            redir.valid = 1'b1;
            redir.pc = {23'd0, r[25:20], 3'b000};
        end
        backendRedirect <= redir;
        r = nextRandom();
        ackDelay <= r[31:29];
    endtask

    task automatic trainTable(input fetchPkg::btbUpdate_t upd);
        logic [3:0] idx;
        idx = upd.pc[6:3];
        // other slot's bit survives only on the same line
        if (!(tblValid[idx] && tblTag[idx] == upd.pc[31:7])) begin
            tblTaken[idx] = 2'b00;
        end
        tblTaken[idx][upd.slot] = upd.taken;
        tblValid[idx] = 1'b1;
        tblTag[idx] = upd.pc[31:7];
        tblTarget[idx] = upd.target;
    endtask

    // group just went out to memory, predict it and the next pc
    task automatic recordLaunch();
        logic [3:0] idx;
        logic hit;
        fetchPkg::fetchGroup_t g;
        assert (memAddr == modelPc) else reportMismatch("launch address", memAddr, modelPc);
        idx = modelPc[6:3];
        hit = tblValid[idx] && (tblTag[idx] == modelPc[31:7]);
        g.pc = modelPc;
        g.inst0 = image[modelPc[12:3]][31:0];
        g.inst1 = image[modelPc[12:3]][63:32];
        g.onlyDs = dsPending;
        g.nlp0.valid = hit;
        g.nlp0.taken = hit && tblTaken[idx][0];
        g.nlp0.target = tblTarget[idx];
        g.nlp1.valid = hit;
        g.nlp1.taken = hit && tblTaken[idx][1];
        g.nlp1.target = tblTarget[idx];
        expected.push_back(g);
        if (dsPending) begin
            modelPc = dsTarget;
            dsPending = 1'b0;
        end else if (g.nlp0.taken) begin
            // delay slot is slot 1 of this group
            modelPc = g.nlp0.target;
        end else if (g.nlp1.taken) begin
            dsTarget = g.nlp1.target;
            dsPending = 1'b1;
            modelPc = modelPc + fetchPkg::GROUP_BYTES;
        end else begin
            modelPc = modelPc + fetchPkg::GROUP_BYTES;
        end
    endtask

    task automatic checkGroup();
        fetchPkg::fetchGroup_t want;
        logic take0;
        logic take1;
        logic bogus;
        assert (expected.size() > 0) else begin
            $display("a group was emitted with no fetch outstanding on the current path");
            stopOnError();
        end
        want = expected.pop_front();
        // a delay-slot group followed none of its predictions
        take0 = want.nlp0.taken && !want.onlyDs;
        take1 = want.nlp1.taken && !want.onlyDs && !take0;
        bogus = (take0 && !isControlTransfer(want.inst0))
            || (take1 && !isControlTransfer(want.inst1));
        want.nlp0.taken = take0 && isControlTransfer(want.inst0);
        want.nlp1.taken = take1 && isControlTransfer(want.inst1);
        assert (fetchOut.pc == want.pc) else reportMismatch("group pc", fetchOut.pc, want.pc);
        assert (fetchOut.inst0 == want.inst0)
            else reportMismatch("inst0", fetchOut.inst0, want.inst0);
        assert (fetchOut.inst1 == want.inst1)
            else reportMismatch("inst1", fetchOut.inst1, want.inst1);
        assert (fetchOut.onlyDs == want.onlyDs)
            else reportMismatch("onlyDs", fetchOut.onlyDs, want.onlyDs);
        assert (fetchOut.nlp0.valid == want.nlp0.valid)
            else reportMismatch("nlp0 valid", fetchOut.nlp0.valid, want.nlp0.valid);
        assert (fetchOut.nlp1.valid == want.nlp1.valid)
            else reportMismatch("nlp1 valid", fetchOut.nlp1.valid, want.nlp1.valid);
        assert (fetchOut.nlp0.taken == want.nlp0.taken)
            else reportMismatch("nlp0 taken", fetchOut.nlp0.taken, want.nlp0.taken);
        assert (fetchOut.nlp1.taken == want.nlp1.taken)
            else reportMismatch("nlp1 taken", fetchOut.nlp1.taken, want.nlp1.taken);
        assert (!want.nlp0.valid || fetchOut.nlp0.target == want.nlp0.target)
            else reportMismatch("nlp0 target", fetchOut.nlp0.target, want.nlp0.target);
        assert (!want.nlp1.valid || fetchOut.nlp1.target == want.nlp1.target)
            else reportMismatch("nlp1 target", fetchOut.nlp1.target, want.nlp1.target);
        if (want.nlp0.taken || want.nlp1.taken) begin
            takenSeen++;
        end
        if (want.onlyDs) begin
            dsSeen++;
        end
        if (bogus) begin
            // pre-decode resumes right after the group
            bogusSeen++;
            modelPc = want.pc + fetchPkg::GROUP_BYTES;
            dsPending = 1'b0;
            expected.delete();
        end
        checkedCount++;
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // model and checks at mid-cycle, where everything is settled
    always @(negedge clk) begin
        if (reset) begin
            modelPc = fetchPkg::RESET_PC;
            dsPending = 1'b0;
            for (int i = 0; i < fetchPkg::BTB_ENTRIES; i++) begin
                tblValid[i] = 1'b0;
            end
            expected.delete();
            prevMemReq = 1'b0;
        end else begin
            // memReq rising means a launch in the cycle before
            if (memReq && !prevMemReq) begin
                recordLaunch();
            end
            if (fetchValid) begin
                checkGroup();
            end
            if (backendRedirect.valid) begin
                redirectSeen++;
                modelPc = backendRedirect.pc;
                dsPending = 1'b0;
                expected.delete();
            end
            if (btbUpdate.valid) begin
                trainTable(btbUpdate);
            end
            prevMemReq = memReq;
        end
    end

    always @(posedge clk) begin
        if (!reset) begin
            driveStimulus();
        end
    end

    initial begin
        rngState = 32'h0482_5fa1;
        holdLeft = 0;
        checkedCount = 0;
        takenSeen = 0;
        dsSeen = 0;
        bogusSeen = 0;
        redirectSeen = 0;
        for (int i = 0; i < IMAGE_GROUPS; i++) begin
            image[i] = {randomWord(), randomWord()};
        end
        reset = 1'b1;
        flush = 1'b0;
        hold = 1'b0;
        backendRedirect = '0;
        btbUpdate = '0;
        ackDelay = 3'd0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        wait (checkedCount >= NUM_GROUPS);
        @(posedge clk);
        if (takenSeen > 0 && dsSeen > 0 && bogusSeen > 0 && redirectSeen > 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            $display("the random run missed one of the taken, delay-slot, bogus or redirect cases");
            stopOnError();
        end
    end

    // watchdog sized from the planned group count
    initial begin
        #((NUM_GROUPS * 40 + 16) * CLK_PERIOD);
        $display("timeout: only %0d of %0d groups were emitted", checkedCount, NUM_GROUPS);
        stopOnError();
    end

endmodule

// ==== build.f ====
logic/fetchPkg.sv
logic/fetchPcSelect.sv
logic/nextLinePredictor.sv
logic/instMemPort.sv
logic/predecodeCheck.sv
logic/fetchFrontend.sv
dv/instMemModel.sv
dv/fetchTb.sv
